// File: src/uart_pkg.sv
package uart_pkg;

  // Data widths
  typedef logic [7:0]  uart_byte_t;   // One serial data byte
  typedef logic [31:0] wb_word_t;     // Wishbone address or data word
  typedef logic [7:0]  reg_offset_t;  // Offset inside the 256-byte window

  // Upper address bits for 0x3000_00xx
  localparam logic [23:0] UART_BASE_TAG = 24'h30_0000;

  // Register map
  localparam reg_offset_t REG_TXDATA = 8'h00;  // Write starts a transmission
  localparam reg_offset_t REG_RXDATA = 8'h04;  // Read pops the RX FIFO
  localparam reg_offset_t REG_STATUS = 8'h08;
  localparam reg_offset_t REG_CTRL   = 8'h0C;

  // STATUS bit positions
  localparam int STATUS_RX_VALID  = 0;  // FIFO holds data
  localparam int STATUS_TX_BUSY   = 1;  // Request pending or frame on the line
  localparam int STATUS_FRAME_ERR = 2;  // Sticky, write 1 to clear
  localparam int STATUS_OVERFLOW  = 3;  // Sticky, write 1 to clear

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,   // Waiting for a falling edge
    RX_START,  // Recheck start bit at half period
    RX_DATA,   // Eight data bits, LSB first
    RX_STOP    // Sample stop bit
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

// File: src/uart_rx.sv
module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       rx_i,
  output uart_byte_t rx_data_o,
  output logic       rx_valid_o,
  output logic       rx_frame_err_o,
  output logic       rx_busy_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  rx_state_e        state_q;
  logic             rx_meta_q;   // First sync stage
  logic             rx_sync_q;   // Safe to use
  logic             rx_prev_q;   // For edge detect
  logic [CNT_W-1:0] cnt_q;       // Clocks within current bit
  logic [2:0]       bit_idx_q;
  uart_byte_t       shift_q;
  logic             fall_edge;
  logic             bit_done;

  // Two-flop synchronizer, idle line is high
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign fall_edge = rx_prev_q & ~rx_sync_q;  // Possible start bit
  assign bit_done  = (cnt_q == FULL_BIT);     // Centre of a data or stop bit
  assign rx_busy_o = (state_q != RX_IDLE);
  assign rx_data_o = shift_q;                 // Stable while valid pulses

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q        <= RX_IDLE;
      cnt_q          <= '0;
      bit_idx_q      <= '0;
      rx_valid_o     <= 1'b0;
      rx_frame_err_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;  // Single-cycle pulse
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (fall_edge) state_q <= RX_START;
        end
        RX_START: begin
          if (cnt_q == HALF_BIT) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Glitch shorter than half a bit goes back to idle
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= RX_STOP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            cnt_q          <= '0;
            rx_valid_o     <= 1'b1;
            rx_frame_err_o <= ~rx_sync_q;  // Stop bit must be high
            state_q        <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data shift register, LSB arrives first
  always_ff @(posedge wb_clk_i) begin
    if (state_q == RX_DATA && bit_done) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  // Back-to-back valid would mean two frames in two clocks
  a_valid_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    rx_valid_o |=> !rx_valid_o)
    else $error("uart_rx: rx_valid_o high for more than one cycle");

endmodule

// File: src/uart_tx.sv
module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       tx_req_i,
  input  uart_byte_t tx_data_i,
  output logic       tx_take_o,
  output logic       tx_busy_o,
  output logic       tx_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  tx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;      // Clocks within current bit
  logic [2:0]       bit_idx_q;
  uart_byte_t       shift_q;    // Bit 0 is on the line during DATA
  logic             bit_done;

  assign bit_done  = (cnt_q == FULL_BIT);
  assign tx_take_o = (state_q == TX_IDLE) && tx_req_i;  // Accept same cycle
  assign tx_busy_o = (state_q != TX_IDLE);              // Drops after stop bit

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_o      <= 1'b1;  // Line idles high
    end else begin
      if (state_q == TX_IDLE || bit_done) cnt_q <= '0;
      else cnt_q <= cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          if (tx_req_i) begin
            state_q <= TX_START;
            tx_o    <= 1'b0;  // Start bit
          end
        end
        TX_START: begin
          if (bit_done) begin
            bit_idx_q <= '0;
            tx_o      <= shift_q[0];
            state_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              tx_o    <= 1'b1;  // Stop bit
              state_q <= TX_STOP;
            end else begin
              tx_o <= shift_q[1];  // Next bit before shift lands
            end
          end
        end
        TX_STOP: if (bit_done) state_q <= TX_IDLE;
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (tx_take_o) shift_q <= tx_data_i;
    else if (state_q == TX_DATA && bit_done) shift_q <= shift_q >> 1;
  end

  a_idle_high: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (state_q == TX_IDLE) |-> tx_o)
    else $error("uart_tx: line not idle high in IDLE");

endmodule

// File: src/uart_rx_fifo.sv
module uart_rx_fifo import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 4  // Power of two
) (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       wr_i,
  input  uart_byte_t wr_data_i,
  input  logic       pop_i,
  output uart_byte_t rd_data_o,
  output logic       not_empty_o,
  output logic       overflow_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  uart_byte_t       mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;   // Wraps naturally at depth
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;    // One extra bit to hold FIFO_DEPTH
  logic             full;
  logic             do_wr;
  logic             do_pop;

  assign full        = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign do_wr       = wr_i & ~full;             // Drop when full
  assign do_pop      = pop_i & (count_q != '0);
  assign not_empty_o = (count_q != '0);
  assign rd_data_o   = mem_q[rd_ptr_q];          // Oldest entry, show-ahead

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= wr_i & full;  // One pulse per dropped byte
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_wr, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage, no reset
  always_ff @(posedge wb_clk_i) begin
    if (do_wr) mem_q[wr_ptr_q] <= wr_data_i;
  end

  a_count_max: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    count_q <= (PTR_W+1)'(FIFO_DEPTH))
    else $error("uart_rx_fifo: count above depth");

  // Register block must only pop while data is present
  a_no_empty_pop: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    pop_i |-> not_empty_o)
    else $error("uart_rx_fifo: pop while empty");

endmodule

// File: src/uart_csr.sv
module uart_csr import uart_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       wbs_cyc_i,
  input  logic       wbs_stb_i,
  input  logic       wbs_we_i,
  input  logic [3:0] wbs_sel_i,        // Not decoded, all registers in lane 0
  input  wb_word_t   wbs_adr_i,
  input  wb_word_t   wbs_dat_i,
  output logic       wbs_ack_o,
  output wb_word_t   wbs_dat_o,
  input  uart_byte_t fifo_data_i,
  input  logic       fifo_not_empty_i,
  input  logic       fifo_overflow_i,
  input  logic       rx_valid_i,
  input  logic       rx_frame_err_i,
  input  logic       tx_take_i,
  input  logic       tx_busy_i,
  output logic       fifo_pop_o,
  output logic       tx_req_o,
  output uart_byte_t tx_data_o,
  output logic       irq_o
);

  logic        wb_valid;    // Access hits this peripheral
  reg_offset_t offset;
  logic        rd_acc;      // Read in its ack cycle
  logic        wr_acc;      // Write in its ack cycle
  logic        tx_wr_ok;    // TXDATA write that is not back-pressured
  logic        frame_err_q;
  logic        overflow_q;
  logic        irq_en_q;
  logic [3:0]  status;

  assign wb_valid = wbs_cyc_i & wbs_stb_i & (wbs_adr_i[31:8] == UART_BASE_TAG);
  assign offset   = reg_offset_t'(wbs_adr_i[7:0]);
  assign rd_acc   = wbs_ack_o & ~wbs_we_i;
  assign wr_acc   = wbs_ack_o & wbs_we_i;
  assign tx_wr_ok = wr_acc & (offset == REG_TXDATA) & ~tx_req_o & ~tx_busy_i;

  // One ack per access, never two in a row
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) wbs_ack_o <= 1'b0;
    else wbs_ack_o <= wb_valid & ~wbs_ack_o;
  end

  // Pop lands on the same edge the read completes
  assign fifo_pop_o = rd_acc & (offset == REG_RXDATA) & fifo_not_empty_i;

  always_comb begin
    status                   = '0;
    status[STATUS_RX_VALID]  = fifo_not_empty_i;
    status[STATUS_TX_BUSY]   = tx_req_o | tx_busy_i;
    status[STATUS_FRAME_ERR] = frame_err_q;
    status[STATUS_OVERFLOW]  = overflow_q;
  end

  // Read mux, zero outside the ack cycle
  always_comb begin
    wbs_dat_o = '0;
    if (rd_acc) begin
      case (offset)
        REG_RXDATA: if (fifo_not_empty_i) wbs_dat_o[7:0] = fifo_data_i;
        REG_STATUS: wbs_dat_o[3:0] = status;
        REG_CTRL:   wbs_dat_o[0]   = irq_en_q;
        default:    wbs_dat_o = '0;  // TXDATA reads back zero
      endcase
    end
  end

  // Transmit request handshake
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) tx_req_o <= 1'b0;
    else if (tx_take_i) tx_req_o <= 1'b0;  // Transmitter has the byte
    else if (tx_wr_ok) tx_req_o <= 1'b1;
  end

  always_ff @(posedge wb_clk_i) begin
    if (tx_wr_ok) tx_data_o <= wbs_dat_i[7:0];
  end

  // Sticky flags, a new event wins over a clear in the same cycle
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      frame_err_q <= 1'b0;
      overflow_q  <= 1'b0;
      irq_en_q    <= 1'b0;
    end else begin
      if (rx_valid_i && rx_frame_err_i) frame_err_q <= 1'b1;
      else if (wr_acc && offset == REG_STATUS && wbs_dat_i[STATUS_FRAME_ERR])
        frame_err_q <= 1'b0;
      if (fifo_overflow_i) overflow_q <= 1'b1;
      else if (wr_acc && offset == REG_STATUS && wbs_dat_i[STATUS_OVERFLOW])
        overflow_q <= 1'b0;
      if (wr_acc && offset == REG_CTRL) irq_en_q <= wbs_dat_i[0];
    end
  end

  assign irq_o = irq_en_q & fifo_not_empty_i;  // Level, follows FIFO state

  // Master keeps the access on the bus through its ack cycle
  a_ack_live: assert property (@(posedge wb_clk_i) disable iff (reset_i)
    wbs_ack_o |-> wb_valid)
    else $error("uart_csr: ack without a live access");

endmodule

// File: src/user_project_uart.sv
module user_project_uart import uart_pkg::*; #(
  parameter int CLK_FREQ_HZ = 40_000_000,
  parameter int BAUD_RATE   = 9600,
  parameter int FIFO_DEPTH  = 4
) (
  input  logic       wb_clk_i,
  input  logic       reset_i,
  input  logic       wbs_cyc_i,
  input  logic       wbs_stb_i,
  input  logic       wbs_we_i,
  input  logic [3:0] wbs_sel_i,
  input  wb_word_t   wbs_adr_i,
  input  wb_word_t   wbs_dat_i,
  output logic       wbs_ack_o,
  output wb_word_t   wbs_dat_o,
  input  logic       rx_i,
  output logic       tx_o,
  output logic       irq_o
);

  localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;  // Bit period in clocks

  uart_byte_t rx_data;
  logic       rx_valid;
  logic       rx_frame_err;
  uart_byte_t fifo_data;
  logic       fifo_not_empty;
  logic       fifo_overflow;
  logic       fifo_pop;
  uart_byte_t tx_data;
  logic       tx_req;
  logic       tx_take;
  logic       tx_busy;

  // Producer side
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i0 (
    .wb_clk_i       (wb_clk_i),
    .reset_i        (reset_i),
    .rx_i           (rx_i),
    .rx_data_o      (rx_data),
    .rx_valid_o     (rx_valid),
    .rx_frame_err_o (rx_frame_err),
    .rx_busy_o      ()                // Receiver activity not mapped to a register
  );

  uart_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i0 (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .wr_i        (rx_valid),        // Frame-error bytes kept too
    .wr_data_i   (rx_data),
    .pop_i       (fifo_pop),
    .rd_data_o   (fifo_data),
    .not_empty_o (fifo_not_empty),
    .overflow_o  (fifo_overflow)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i0 (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .tx_req_i  (tx_req),
    .tx_data_i (tx_data),
    .tx_take_o (tx_take),
    .tx_busy_o (tx_busy),
    .tx_o      (tx_o)
  );

  // Consumer of RX bytes, source of TX requests
  uart_csr csr_i0 (
    .wb_clk_i         (wb_clk_i),
    .reset_i          (reset_i),
    .wbs_cyc_i        (wbs_cyc_i),
    .wbs_stb_i        (wbs_stb_i),
    .wbs_we_i         (wbs_we_i),
    .wbs_sel_i        (wbs_sel_i),
    .wbs_adr_i        (wbs_adr_i),
    .wbs_dat_i        (wbs_dat_i),
    .wbs_ack_o        (wbs_ack_o),
    .wbs_dat_o        (wbs_dat_o),
    .fifo_data_i      (fifo_data),
    .fifo_not_empty_i (fifo_not_empty),
    .fifo_overflow_i  (fifo_overflow),
    .rx_valid_i       (rx_valid),
    .rx_frame_err_i   (rx_frame_err),
    .tx_take_i        (tx_take),
    .tx_busy_i        (tx_busy),
    .fifo_pop_o       (fifo_pop),
    .tx_req_o         (tx_req),
    .tx_data_o        (tx_data),
    .irq_o            (irq_o)
  );

endmodule

// File: verification/tb_uart.sv
module tb_uart;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_FREQ_HZ  = 25_000_000;
  localparam int BAUD_RATE    = 1_562_500;
  localparam int FIFO_DEPTH   = 4;
  localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;  // 16
  localparam int CLK_NS       = 40;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam logic [31:0] BASE_ADDR = 32'h3000_0000;
  localparam logic [7:0] OFF_TXDATA = 8'h00;
  localparam logic [7:0] OFF_RXDATA = 8'h04;
  localparam logic [7:0] OFF_STATUS = 8'h08;
  localparam logic [7:0] OFF_CTRL   = 8'h0C;
  localparam int TX_BYTES   = 20;
  localparam int RX_BURSTS  = 10;
  localparam int ACK_LIMIT  = 16;
  localparam int POLL_LIMIT = 200;  // STATUS polls, covers two frames
  // Every frame the run can put on either line, 10 bits each
  localparam int MAX_FRAMES = TX_BYTES + 2 + RX_BURSTS * FIFO_DEPTH + 6 + 1;
  localparam int WATCHDOG_CYCLES = MAX_FRAMES * 10 * CLKS_PER_BIT + 20_000;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  sel;
  logic [31:0] adr;
  logic [31:0] wdata;
  logic        ack;
  logic [31:0] rdata;
  logic        rx_line;
  logic        tx_line;
  logic        irq;

  int          errors = 0;
  int          checks = 0;
  string       test_name = "reset";
  logic [7:0]  rx_model_q[$];  // Bytes the FIFO should hold, oldest first
  logic        model_ovf = 1'b0;
  logic        model_ferr = 1'b0;
  logic        model_irq_en = 1'b0;
  logic [7:0]  tx_expect_q[$];
  logic [7:0]  tx_seen_q[$];   // Filled by the line monitor

  user_project_uart #(
    .CLK_FREQ_HZ (CLK_FREQ_HZ),
    .BAUD_RATE   (BAUD_RATE),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) dut_i (
    .wb_clk_i  (clk),
    .reset_i   (reset),
    .wbs_cyc_i (cyc),
    .wbs_stb_i (stb),
    .wbs_we_i  (we),
    .wbs_sel_i (sel),
    .wbs_adr_i (adr),
    .wbs_dat_i (wdata),
    .wbs_ack_o (ack),
    .wbs_dat_o (rdata),
    .rx_i      (rx_line),
    .tx_o      (tx_line),
    .irq_o     (irq)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // One Wishbone cycle, held until ack
  task automatic bus_access(input logic write, input logic [7:0] offset,
                            input logic [31:0] data_in, output logic [31:0] data_out);
    int waited;
    waited = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= BASE_ADDR | 32'(offset);
    wdata <= data_in;
    do begin
      @(negedge clk);  // Ack and read data settled
      waited++;
    end while (ack !== 1'b1 && waited < ACK_LIMIT);
    data_out = rdata;
    if (ack !== 1'b1) begin
      errors++;
      $display("no ack for access to offset %h in test %s", offset, test_name);
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, offset, data, unused);
  endtask

  task automatic read_reg(input logic [7:0] offset, output logic [31:0] data);
    bus_access(1'b0, offset, 32'd0, data);
  endtask

  // 8N1 frame on rx, then one idle bit
  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    @(posedge clk);
    rx_line <= 1'b0;
    repeat (CLKS_PER_BIT) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      rx_line <= data[i];  // LSB first
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    rx_line <= stop_bit;
    repeat (CLKS_PER_BIT) @(posedge clk);
    rx_line <= 1'b1;
    repeat (CLKS_PER_BIT) @(posedge clk);  // Receiver done by now
  endtask

  // Sends a byte and updates the model the way the FIFO should
  task automatic receive_byte(input logic [7:0] data, input logic stop_bit);
    send_frame(data, stop_bit);
    if (rx_model_q.size() < FIFO_DEPTH) rx_model_q.push_back(data);
    else model_ovf = 1'b1;  // Dropped byte
    if (!stop_bit) model_ferr = 1'b1;
  endtask

  function automatic logic [31:0] expected_status();
    return {28'd0, model_ovf, model_ferr, 1'b0, rx_model_q.size() != 0};
  endfunction

  task automatic check_irq();
    @(negedge clk);
    check_eq("irq", {31'd0, model_irq_en && rx_model_q.size() != 0}, {31'd0, irq});
  endtask

  // Read RXDATA until rx-valid drops
  task automatic drain_rx();
    logic [31:0] st;
    logic [31:0] d;
    logic [7:0]  exp;
    int guard;
    guard = 0;
    do begin
      read_reg(OFF_STATUS, st);
      check_eq("status", expected_status(), st);
      if (st[0] === 1'b1) begin
        read_reg(OFF_RXDATA, d);
        if (rx_model_q.size() == 0) begin
          errors++;
          $display("RXDATA returned a byte nobody sent in test %s", test_name);
        end else begin
          exp = rx_model_q.pop_front();
          check_eq("rxdata", {24'd0, exp}, d);
        end
      end
      guard++;
    end while (st[0] === 1'b1 && guard < 2 * FIFO_DEPTH + 2);
    if (rx_model_q.size() != 0) begin
      errors++;
      $display("rx valid dropped with %0d bytes still expected in test %s",
               rx_model_q.size(), test_name);
      rx_model_q.delete();
    end
  endtask

  task automatic wait_tx_idle();
    logic [31:0] st;
    int polls;
    polls = 0;
    do begin
      read_reg(OFF_STATUS, st);
      polls++;
    end while (st[1] !== 1'b0 && polls < POLL_LIMIT);
    if (st[1] !== 1'b0) begin
      errors++;
      $display("tx busy never cleared in test %s", test_name);
    end
  endtask

  task automatic compare_tx();
    check_eq("tx byte count", tx_expect_q.size(), tx_seen_q.size());
    for (int i = 0; i < tx_expect_q.size() && i < tx_seen_q.size(); i++)
      check_eq($sformatf("tx byte %0d", i), {24'd0, tx_expect_q[i]}, {24'd0, tx_seen_q[i]});
    tx_expect_q.delete();
    tx_seen_q.delete();
  endtask

  // Line monitor, samples tx at bit centres on falling clock edges
  initial begin : tx_monitor
    logic [7:0] data;
    @(negedge reset);
    forever begin
      @(negedge tx_line);
      #(BIT_NS / 2 + CLK_NS / 2);
      if (tx_line !== 1'b0) begin
        errors++;
        $display("tx start bit did not stay low");
      end
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        data[i] = tx_line;
      end
      #(BIT_NS);
      if (tx_line !== 1'b1) begin
        errors++;
        $display("tx stop bit was not high");
      end
      tx_seen_q.push_back(data);
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    logic [31:0] d;
    logic [7:0]  b;
    logic [7:0]  first;
    logic        en;
    int          burst;
    clk     = 1'b0;
    reset   = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    sel     = 4'hF;
    adr     = 32'd0;
    wdata   = 32'd0;
    rx_line = 1'b1;  // Idle line
    void'($urandom(32'h5d53352d));
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    check_eq("tx line", 32'd1, {31'd0, tx_line});
    check_eq("irq", 32'd0, {31'd0, irq});
    read_reg(OFF_STATUS, d);
    check_eq("status", expected_status(), d);

    test_name = "transmit";
    for (int i = 0; i < TX_BYTES; i++) begin
      wait_tx_idle();
      b = 8'($urandom);
      write_reg(OFF_TXDATA, {24'd0, b});
      tx_expect_q.push_back(b);
    end
    wait_tx_idle();
    compare_tx();

    test_name = "backpressure";
    first = 8'($urandom);
    write_reg(OFF_TXDATA, {24'd0, first});
    write_reg(OFF_TXDATA, {24'd0, ~first});  // Lands while busy
    tx_expect_q.push_back(first);
    wait_tx_idle();
    repeat (12 * CLKS_PER_BIT) @(posedge clk);  // Room for a wrong second frame
    compare_tx();

    test_name = "receive";
    for (int k = 0; k < RX_BURSTS; k++) begin
      burst = 1 + ($urandom % FIFO_DEPTH);
      for (int j = 0; j < burst; j++) receive_byte(8'($urandom), 1'b1);
      en = 1'($urandom);
      write_reg(OFF_CTRL, {31'd0, en});
      model_irq_en = en;
      read_reg(OFF_CTRL, d);
      check_eq("ctrl", {31'd0, en}, d);
      check_irq();
      drain_rx();
      check_irq();  // Empty FIFO, irq low
    end

    test_name = "overflow";
    for (int j = 0; j < 6; j++) receive_byte(8'($urandom), 1'b1);
    drain_rx();
    write_reg(OFF_STATUS, 32'h8);
    model_ovf = 1'b0;
    read_reg(OFF_STATUS, d);
    check_eq("status", expected_status(), d);

    test_name = "frame_error";
    receive_byte(8'($urandom), 1'b0);
    drain_rx();
    write_reg(OFF_STATUS, 32'h4);
    model_ferr = 1'b0;
    read_reg(OFF_STATUS, d);
    check_eq("status", expected_status(), d);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: build.f
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_rx_fifo.sv
src/uart_csr.sv
src/user_project_uart.sv
verification/tb_uart.sv

// File: Bender.yml
package:
  name: user_project_uart

sources:
  # Package first, then leaf blocks, then the top level
  - src/uart_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/uart_rx_fifo.sv
  - src/uart_csr.sv
  - src/user_project_uart.sv

  # Testbench, top module tb_uart
  - target: test
    files:
      - verification/tb_uart.sv
